//--- common/uart_rx_pkg.sv
package uart_rx_pkg;

	// Number of serial lines handled by the receiver block.
	localparam int NUM_CH = 4;
	localparam int CH_W = 2;

	// Receive FIFO geometry. The fill count needs one bit more than the pointers.
	localparam int FIFO_DEPTH = 8;
	localparam int CNT_W = 4;

	localparam int BAUD_W = 16;

	typedef logic [7:0] rx_byte_t;
	typedef logic [BAUD_W-1:0] baud_inc_t;
	typedef logic [CH_W-1:0] ch_id_t;
	typedef logic [CNT_W-1:0] fifo_cnt_t;

	// Line settings, shared by all channels.
	typedef struct packed {
		logic parity_enable;
		logic parity_odd;
		baud_inc_t baud_inc;
	} rx_cfg_t;

	// What one receiver hands over with its valid pulse.
	typedef struct packed {
		rx_byte_t data;
		logic frame_err;
		logic parity_err;
	} rx_result_t;

	// One FIFO entry, tagged with the line it came from.
	typedef struct packed {
		ch_id_t ch;
		rx_byte_t data;
		logic frame_err;
		logic parity_err;
	} rx_entry_t;

	typedef enum logic {
		RX_IDLE,
		RX_RECEIVING
	} rx_state_e;

endpackage

//--- hw/baud_tick_gen.sv
`timescale 1ns/1ps

module baud_tick_gen (
	input logic clk_i,
	input logic rst_ni,
	input uart_rx_pkg::baud_inc_t baud_inc,
	output logic tick_x16
);
	import uart_rx_pkg::*;

	logic [BAUD_W-1:0] acc_q;
	logic [BAUD_W-1:0] acc_d;
	logic carry;
	logic tick_q;

	// The tick rate is clk * baud_inc / 2^BAUD_W, so any baud rate can be
	// reached from one clock with a small fractional error.
	always_comb begin
		{carry, acc_d} = {1'b0, acc_q} + {1'b0, baud_inc};
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			acc_q <= '0;
			tick_q <= 1'b0;
		end else begin
			acc_q <= acc_d;
			tick_q <= carry;
		end
	end

	assign tick_x16 = tick_q;

endmodule

//--- uart_rx/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
	input logic clk_i,
	input logic rst_ni,
	input logic rx_enable,
	input logic tick_baud_x16,
	input logic parity_enable,
	input logic parity_odd,
	input logic rx,
	output logic rx_valid,
	output uart_rx_pkg::rx_result_t result,
	output logic idle
);
	import uart_rx_pkg::*;

	rx_state_e state_q;
	rx_state_e state_d;
	logic [10:0] sreg_q;
	logic [10:0] sreg_d;
	logic [3:0] bit_cnt_q;
	logic [3:0] bit_cnt_d;
	logic [3:0] baud_div_q;
	logic [3:0] baud_div_d;
	logic tick_baud_q;
	logic tick_baud_d;
	logic rx_valid_q;
	logic [3:0] frame_bits;

	// Start, eight data bits, optional parity and stop.
	assign frame_bits = parity_enable ? 4'd11 : 4'd10;

	always_comb begin
		state_d = state_q;
		sreg_d = sreg_q;
		bit_cnt_d = bit_cnt_q;
		baud_div_d = baud_div_q;
		tick_baud_d = 1'b0;
		if (!rx_enable) begin
			state_d = RX_IDLE;
			sreg_d = '0;
			bit_cnt_d = '0;
			baud_div_d = '0;
		end else begin
			if (tick_baud_x16) begin
				{tick_baud_d, baud_div_d} = {1'b0, baud_div_q} + 5'd1;
			end
			if (state_q == RX_IDLE) begin
				// The divider starts at half a bit, so every later bit
				// tick lands in the middle of its bit time.
				if (!rx) begin
					state_d = RX_RECEIVING;
					baud_div_d = 4'd8;
					tick_baud_d = 1'b0;
					bit_cnt_d = frame_bits;
					sreg_d = '0;
				end
			end else if (bit_cnt_q == 4'd0) begin
				// A low stop bit was seen; wait for the line to release.
				if (rx) begin
					state_d = RX_IDLE;
				end
			end else if (tick_baud_q) begin
				if (bit_cnt_q == frame_bits && rx) begin
					state_d = RX_IDLE;
					bit_cnt_d = '0;
				end else begin
					sreg_d = {rx, sreg_q[10:1]};
					bit_cnt_d = bit_cnt_q - 4'd1;
					if (bit_cnt_q == 4'd1 && rx) begin
						state_d = RX_IDLE;
					end
				end
			end
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= RX_IDLE;
			bit_cnt_q <= '0;
			baud_div_q <= '0;
			tick_baud_q <= 1'b0;
			rx_valid_q <= 1'b0;
		end else begin
			state_q <= state_d;
			bit_cnt_q <= bit_cnt_d;
			baud_div_q <= baud_div_d;
			tick_baud_q <= tick_baud_d;
			rx_valid_q <= rx_enable & tick_baud_q & (state_q == RX_RECEIVING) &
				(bit_cnt_q == 4'd1);
		end
	end

	always_ff @(posedge clk_i) begin
		sreg_q <= sreg_d;
	end

	assign rx_valid = rx_valid_q;
	assign idle = !rx_enable || (state_q == RX_IDLE);

	// The stop bit always ends up in bit 10; the data sits one place lower
	// when a parity bit follows it.
	assign result.data = parity_enable ? sreg_q[8:1] : sreg_q[9:2];
	assign result.frame_err = rx_valid_q & ~sreg_q[10];
	assign result.parity_err = rx_valid_q & parity_enable & (^{sreg_q[9:1], parity_odd});

endmodule

//--- hw/rx_collector.sv
`timescale 1ns/1ps

module rx_collector (
	input logic clk_i,
	input logic rst_ni,
	input logic [uart_rx_pkg::NUM_CH-1:0] rx_valid,
	input uart_rx_pkg::rx_result_t result [uart_rx_pkg::NUM_CH],
	input logic rd,
	input logic clr_overrun,
	output uart_rx_pkg::rx_entry_t rd_data,
	output logic rd_avail,
	output uart_rx_pkg::fifo_cnt_t fill,
	output logic [uart_rx_pkg::NUM_CH-1:0] overrun
);
	import uart_rx_pkg::*;

	// Per-channel holding stage.
	logic [NUM_CH-1:0] hold_full_q;
	rx_result_t hold_q [NUM_CH];
	logic [NUM_CH-1:0] drain;
	logic [NUM_CH-1:0] accept;
	logic [NUM_CH-1:0] ovr_set;
	logic [NUM_CH-1:0] overrun_q;

	// Round-robin picker.
	ch_id_t rr_ptr_q;
	ch_id_t grant_ch;
	logic grant_valid;

	// Receive FIFO.
	rx_entry_t mem [FIFO_DEPTH];
	rx_entry_t wr_entry;
	logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr_q;
	logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr_q;
	fifo_cnt_t count_q;
	logic fifo_full;
	logic push;
	logic pop;

	assign fifo_full = (count_q == fifo_cnt_t'(FIFO_DEPTH));

	// The search starts one past the last granted channel and wraps around
	// to that channel last.
	always_comb begin
		ch_id_t cand;
		grant_valid = 1'b0;
		grant_ch = rr_ptr_q;
		for (int i = 1; i <= NUM_CH; i++) begin
			cand = rr_ptr_q + ch_id_t'(i);
			if (!grant_valid && !fifo_full && hold_full_q[cand]) begin
				grant_valid = 1'b1;
				grant_ch = cand;
			end
		end
	end

	always_comb begin
		for (int k = 0; k < NUM_CH; k++) begin
			drain[k] = grant_valid && (grant_ch == ch_id_t'(k));
			// A slot being emptied this cycle can take the new byte.
			accept[k] = rx_valid[k] && (!hold_full_q[k] || drain[k]);
			ovr_set[k] = rx_valid[k] && hold_full_q[k] && !drain[k];
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			hold_full_q <= '0;
			overrun_q <= '0;
			rr_ptr_q <= ch_id_t'(NUM_CH - 1);
		end else begin
			hold_full_q <= accept | (hold_full_q & ~drain);
			overrun_q <= (overrun_q & ~{NUM_CH{clr_overrun}}) | ovr_set;
			if (grant_valid) begin
				rr_ptr_q <= grant_ch;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		for (int k = 0; k < NUM_CH; k++) begin
			if (accept[k]) begin
				hold_q[k] <= result[k];
			end
		end
	end

	assign push = grant_valid;
	assign pop = rd && rd_avail;

	always_comb begin
		wr_entry.ch = grant_ch;
		wr_entry.data = hold_q[grant_ch].data;
		wr_entry.frame_err = hold_q[grant_ch].frame_err;
		wr_entry.parity_err = hold_q[grant_ch].parity_err;
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end else begin
			if (push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			if (push && !pop) begin
				count_q <= count_q + 1'b1;
			end else if (pop && !push) begin
				count_q <= count_q - 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (push) begin
			mem[wr_ptr_q] <= wr_entry;
		end
	end

	assign rd_data = mem[rd_ptr_q];
	assign rd_avail = (count_q != '0);
	assign fill = count_q;
	assign overrun = overrun_q;

endmodule

//--- hw/uart_rx_top.sv
`timescale 1ns/1ps

module uart_rx_top (
	input logic clk_i,
	input logic rst_ni,
	input logic [uart_rx_pkg::NUM_CH-1:0] rx,
	input logic [uart_rx_pkg::NUM_CH-1:0] rx_enable,
	input uart_rx_pkg::rx_cfg_t cfg,
	input logic rd,
	input logic clr_overrun,
	output uart_rx_pkg::rx_entry_t rd_data,
	output logic rd_avail,
	output uart_rx_pkg::fifo_cnt_t fill,
	output logic [uart_rx_pkg::NUM_CH-1:0] overrun,
	output logic [uart_rx_pkg::NUM_CH-1:0] idle
);
	import uart_rx_pkg::*;

	logic tick_x16;
	logic [NUM_CH-1:0] rx_valid;
	rx_result_t result [NUM_CH];

	// One oversampling tick serves every line.
	baud_tick_gen u_baud_tick_gen (
		.clk_i(clk_i),
		.rst_ni(rst_ni),
		.baud_inc(cfg.baud_inc),
		.tick_x16(tick_x16)
	);

	for (genvar k = 0; k < NUM_CH; k++) begin : g_rx
		uart_rx u_uart_rx (
			.clk_i(clk_i),
			.rst_ni(rst_ni),
			.rx_enable(rx_enable[k]),
			.tick_baud_x16(tick_x16),
			.parity_enable(cfg.parity_enable),
			.parity_odd(cfg.parity_odd),
			.rx(rx[k]),
			.rx_valid(rx_valid[k]),
			.result(result[k]),
			.idle(idle[k])
		);
	end

	rx_collector u_rx_collector (
		.clk_i(clk_i),
		.rst_ni(rst_ni),
		.rx_valid(rx_valid),
		.result(result),
		.rd(rd),
		.clr_overrun(clr_overrun),
		.rd_data(rd_data),
		.rd_avail(rd_avail),
		.fill(fill),
		.overrun(overrun)
	);

endmodule

//--- tb/uart_rx_top_props.sv
`timescale 1ns/1ps

module uart_rx_top_props (
	input logic clk_i,
	input logic rst_ni,
	input logic [uart_rx_pkg::NUM_CH-1:0] rx_valid,
	input logic [uart_rx_pkg::NUM_CH-1:0] rx_enable,
	input logic [uart_rx_pkg::NUM_CH-1:0] idle,
	input uart_rx_pkg::fifo_cnt_t fill,
	input logic rd_avail,
	input logic rd,
	input uart_rx_pkg::rx_entry_t rd_data
);
	import uart_rx_pkg::*;

	// Number of assertion failures seen so far.
	int fail_cnt = 0;

	for (genvar k = 0; k < NUM_CH; k++) begin : g_ch
		a_valid_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
			rx_valid[k] |=> !rx_valid[k])
		else begin
			$error("rx_valid of channel %0d stayed high for two cycles", k);
			fail_cnt++;
		end

		// A disabled receiver has dropped back to idle by the next cycle,
		// even if it is enabled again right away.
		a_idle_disabled: assert property (@(posedge clk_i) disable iff (!rst_ni)
			!rx_enable[k] |=> idle[k])
		else begin
			$error("channel %0d did not return to idle after being disabled", k);
			fail_cnt++;
		end
	end

	a_fill_max: assert property (@(posedge clk_i) disable iff (!rst_ni)
		fill <= fifo_cnt_t'(FIFO_DEPTH))
	else begin
		$error("FIFO fill %0d is above its depth", fill);
		fail_cnt++;
	end

	a_avail_fill: assert property (@(posedge clk_i) disable iff (!rst_ni)
		rd_avail == (fill != '0))
	else begin
		$error("rd_avail does not match a fill of %0d", fill);
		fail_cnt++;
	end

	// The head may only change when it is read.
	a_head_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(rd_avail && !rd) |=> $stable(rd_data))
	else begin
		$error("rd_data changed without a read");
		fail_cnt++;
	end

endmodule

bind uart_rx_top uart_rx_top_props u_props (
	.clk_i(clk_i),
	.rst_ni(rst_ni),
	.rx_valid(rx_valid),
	.rx_enable(rx_enable),
	.idle(idle),
	.fill(fill),
	.rd_avail(rd_avail),
	.rd(rd),
	.rd_data(rd_data)
);

//--- tb/tb_uart_rx_top.sv
`timescale 1ns/1ps

module tb_uart_rx_top;
	import uart_rx_pkg::*;

	localparam int CLK_NS = 4;
	localparam int BIT_CYCLES = 16;
	localparam int NUM_FRAMES = 42;
	// Each frame is budgeted at twelve bit times.
	localparam int WATCHDOG_NS = NUM_FRAMES * 12 * BIT_CYCLES * CLK_NS + 4000;

	logic clk_i = 1'b0;
	logic rst_ni;
	logic [NUM_CH-1:0] rx;
	logic [NUM_CH-1:0] rx_enable;
	rx_cfg_t cfg;
	logic rd;
	logic clr_overrun;
	rx_entry_t rd_data;
	logic rd_avail;
	fifo_cnt_t fill;
	logic [NUM_CH-1:0] overrun;
	logic [NUM_CH-1:0] idle;

	// Expected entries, one queue per channel.
	rx_entry_t exp_q [NUM_CH][$];
	int pending = 0;
	int reads = 0;
	int errors = 0;
	int seed = 53;
	logic auto_read = 1'b0;

	uart_rx_top UUT (
		.clk_i(clk_i),
		.rst_ni(rst_ni),
		.rx(rx),
		.rx_enable(rx_enable),
		.cfg(cfg),
		.rd(rd),
		.clr_overrun(clr_overrun),
		.rd_data(rd_data),
		.rd_avail(rd_avail),
		.fill(fill),
		.overrun(overrun),
		.idle(idle)
	);

	always #(CLK_NS / 2) clk_i = ~clk_i;

	function automatic void expect_byte(input int ch, input rx_byte_t data, input logic bad_par,
			input logic bad_stop);
		rx_entry_t e;
		e.ch = ch_id_t'(ch);
		e.data = data;
		e.frame_err = bad_stop;
		e.parity_err = bad_par & cfg.parity_enable;
		exp_q[ch].push_back(e);
		pending++;
	endfunction

	task automatic check_entry(input rx_entry_t got);
		rx_entry_t exp;
		reads++;
		assert (exp_q[got.ch].size() != 0) else begin
			errors++;
			$display("Error at %0t ns: unexpected entry on channel %0d with data %h",
				$time, got.ch, got.data);
		end
		if (exp_q[got.ch].size() != 0) begin
			exp = exp_q[got.ch].pop_front();
			pending--;
			assert (got == exp) else begin
				errors++;
				$display("Error at %0t ns: channel %0d expected %h fe %b pe %b, got %h fe %b pe %b",
					$time, got.ch, exp.data, exp.frame_err, exp.parity_err, got.data,
					got.frame_err, got.parity_err);
			end
		end
	endtask

	// Start bit, data LSB first, optional parity, stop bit.
	task automatic send_frame(input int ch, input rx_byte_t data, input logic bad_par,
			input logic bad_stop);
		logic [10:0] bits;
		int n;
		if (cfg.parity_enable) begin
			bits = {~bad_stop, ^data ^ cfg.parity_odd ^ bad_par, data, 1'b0};
			n = 11;
		end else begin
			bits = {1'b0, ~bad_stop, data, 1'b0};
			n = 10;
		end
		@(posedge clk_i);
		#1;
		for (int i = 0; i < n; i++) begin
			rx[ch] = bits[i];
			repeat (BIT_CYCLES) @(posedge clk_i);
			#1;
		end
		if (bad_stop) begin
			rx[ch] = 1'b1;
			repeat (2 * BIT_CYCLES) @(posedge clk_i);
			#1;
		end
	endtask

	task automatic send_all(input logic [NUM_CH-1:0] mask, input logic [NUM_CH-1:0] bad_par,
			input logic [NUM_CH-1:0] bad_stop);
		rx_byte_t d [NUM_CH];
		for (int k = 0; k < NUM_CH; k++) begin
			d[k] = rx_byte_t'($random(seed));
			if (mask[k]) begin
				expect_byte(k, d[k], bad_par[k], bad_stop[k]);
			end
		end
		for (int k = 0; k < NUM_CH; k++) begin
			if (mask[k]) begin
				automatic int c = k;
				fork
					send_frame(c, d[c], bad_par[c], bad_stop[c]);
				join_none
			end
		end
		wait fork;
	endtask

	task automatic wait_drained(input int max_cycles);
		int n;
		n = 0;
		while (pending != 0 && n < max_cycles) begin
			@(posedge clk_i);
			n++;
		end
		#1;
		assert (pending == 0) else begin
			errors++;
			$display("The FIFO did not deliver %0d expected entries by %0t ns.", pending, $time);
		end
	endtask

	task automatic wait_fill(input fifo_cnt_t target, input int max_cycles);
		int n;
		n = 0;
		while (fill != target && n < max_cycles) begin
			@(posedge clk_i);
			n++;
		end
		#1;
		assert (fill == target) else begin
			errors++;
			$display("Error at %0t ns: fill is %0d, expected %0d", $time, fill, target);
		end
	endtask

	task automatic check_empty();
		repeat (4) @(posedge clk_i);
		#1;
		assert (fill == '0 && !rd_avail) else begin
			errors++;
			$display("Error at %0t ns: FIFO should be empty but holds %0d entries", $time, fill);
		end
	endtask

	// Reader that pops the head every cycle while auto_read is set.
	initial begin
		rd = 1'b0;
		forever begin
			@(posedge clk_i);
			#1;
			if (auto_read && rd_avail) begin
				check_entry(rd_data);
				rd = 1'b1;
			end else begin
				rd = 1'b0;
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns.", WATCHDOG_NS);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		rst_ni = 1'b0;
		rx = '1;
		rx_enable = '1;
		cfg.parity_enable = 1'b0;
		cfg.parity_odd = 1'b0;
		cfg.baud_inc = baud_inc_t'(65535);
		clr_overrun = 1'b0;
		repeat (3) @(posedge clk_i);
		#1;
		rst_ni = 1'b1;
		assert (idle == '1 && fill == '0 && !rd_avail && overrun == '0) else begin
			errors++;
			$display("Error at %0t ns: after reset idle %b fill %0d avail %b overrun %b",
				$time, idle, fill, rd_avail, overrun);
		end
		auto_read = 1'b1;

		for (int k = 0; k < NUM_CH; k++) begin
			send_all({{(NUM_CH-1){1'b0}}, 1'b1} << k, '0, '0);
			wait_drained(40);
		end

		cfg.parity_enable = 1'b1;
		for (int m = 0; m < 2; m++) begin
			cfg.parity_odd = (m == 1);
			send_all('1, '0, '0);
			send_all('1, (m == 1) ? 4'b1000 : 4'b0010, '0);
			wait_drained(40);
		end

		// A low stop bit, then a clean frame on the same line.
		send_all(4'b0001, '0, 4'b0001);
		wait_drained(40);
		assert (idle[0]) else begin
			errors++;
			$display("Error at %0t ns: channel 0 idle is %b after the line went high",
				$time, idle[0]);
		end
		send_all(4'b0001, '0, '0);
		wait_drained(40);

		cfg.parity_enable = 1'b0;
		send_all('1, '0, '0);
		send_all('1, '0, '0);
		wait_drained(40);

		auto_read = 1'b0;
		send_all('1, '0, '0);
		send_all('1, '0, '0);
		wait_fill(fifo_cnt_t'(FIFO_DEPTH), 40);
		send_all(4'b0010, '0, '0);
		send_frame(1, rx_byte_t'($random(seed)), 1'b0, 1'b0);
		assert (overrun == 4'b0010 && fill == fifo_cnt_t'(FIFO_DEPTH)) else begin
			errors++;
			$display("Error at %0t ns: overrun %b fill %0d after the lost byte",
				$time, overrun, fill);
		end
		clr_overrun = 1'b1;
		@(posedge clk_i);
		#1;
		clr_overrun = 1'b0;
		assert (overrun == '0) else begin
			errors++;
			$display("Error at %0t ns: overrun %b after clr_overrun", $time, overrun);
		end
		auto_read = 1'b1;
		wait_drained(60);
		check_empty();

		// Channel 2 is off while its line toggles next to a live channel 3.
		rx_enable = 4'b1011;
		fork
			send_all(4'b1000, '0, '0);
			send_frame(2, rx_byte_t'($random(seed)), 1'b0, 1'b0);
		join
		wait_drained(40);
		check_empty();
		rx_enable = '1;

		$display("Reads: %0d, errors: %0d, assertion failures: %0d",
			reads, errors, UUT.u_props.fail_cnt);
		if (errors == 0 && UUT.u_props.fail_cnt == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- list.f
common/uart_rx_pkg.sv
hw/baud_tick_gen.sv
uart_rx/uart_rx.sv
hw/rx_collector.sv
hw/uart_rx_top.sv
tb/uart_rx_top_props.sv
tb/tb_uart_rx_top.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the four-channel UART receiver testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_uart_rx_top \
	-f list.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/Vtb_uart_rx_top +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Result: PASSED" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
